// ==== include/jsp_cfg.svh ====
////////////////////
// Build-time constants of the JTAG serial port
// Included by the package, the RTL and the testbench
////////////////////

`ifndef JSP_CFG_SVH
`define JSP_CFG_SVH

// Width of one transferred byte
`define JSP_WORD_W     8
// Width of the free space and byte count nibbles
`define JSP_COUNT_W    4
// Entries per FIFO, must fit in a count nibble
`define JSP_FIFO_DEPTH 8
// Index of the last bit of a byte
`define JSP_BIT_MAX    7
// Value on tdi that opens a host write
`define JSP_START_BIT  1'b1

`endif

// ==== logic/jsp_pkg.sv ====
////////////////////
// Shared types of the JTAG serial port
// Referenced by scoped name from the RTL and the testbench
////////////////////

`include "jsp_cfg.svh"

package jsp_pkg;

  typedef logic [`JSP_WORD_W-1:0]          byte_t;     // One transferred byte
  typedef logic [`JSP_COUNT_W-1:0]         count_t;    // Bytes or free space
  typedef logic [$clog2(`JSP_WORD_W)-1:0]  bit_cnt_t;  // Bit position in a byte

  // Input FSM, host to device
  typedef enum logic [1:0] {
    WR_IDLE   = 2'd0,  // No scan
    WR_WAIT   = 2'd1,  // Waiting for the start bit
    WR_COUNTS = 2'd2,  // Count byte
    WR_XFER   = 2'd3   // Data bytes
  } wr_state_t;

  // Output FSM, device to host
  typedef enum logic [1:0] {
    RD_IDLE   = 2'd0,  // No scan
    RD_COUNTS = 2'd1,  // Status byte
    RD_RDACK  = 2'd2,  // First bit of a data byte
    RD_XFER   = 2'd3   // Rest of a data byte
  } rd_state_t;

endpackage

// ==== logic/jsp_fifo.sv ====
////////////////////
// Circular byte FIFO with an occupancy count
// Push when full and pop when empty are ignored
////////////////////

`timescale 1ns/1ns

`include "jsp_cfg.svh"

module jsp_fifo (
  input  logic            tck_i,
  input  logic            rst_i,
  input  logic            push_i,       // Write push_data_i
  input  jsp_pkg::byte_t  push_data_i,
  input  logic            pop_i,        // Drop the head
  output jsp_pkg::byte_t  head_o,       // Oldest entry
  output jsp_pkg::count_t count_o,      // Entries held
  output logic            full_o
);

  localparam int PTR_W = $clog2(`JSP_FIFO_DEPTH);

  jsp_pkg::byte_t  mem_q [`JSP_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  jsp_pkg::count_t count_q;
  logic            do_push;
  logic            do_pop;

  assign full_o  = (count_q == jsp_pkg::count_t'(`JSP_FIFO_DEPTH));
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && (count_q != '0);
  assign head_o  = mem_q[rd_ptr_q];
  assign count_o = count_q;

  // Storage array
  always_ff @(posedge tck_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      if (do_pop)  rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + jsp_pkg::count_t'(1);
        2'b01:   count_q <= count_q - jsp_pkg::count_t'(1);
        default: count_q <= count_q;  // Idle or both at once
      endcase
    end
  end

endmodule

// ==== logic/jsp_bus_unit.sv ====
////////////////////
// System side of the JTAG serial port
// Holds the receive and transmit FIFOs and runs the two
// four-phase req/ack byte ports
////////////////////

`timescale 1ns/1ns

`include "jsp_cfg.svh"

module jsp_bus_unit (
  input  logic            tck_i,
  input  logic            rst_i,
  // JTAG side
  input  logic            wr_strobe_i,    // Push wr_data_i into rx FIFO
  input  jsp_pkg::byte_t  wr_data_i,
  output jsp_pkg::count_t space_avail_o,  // Free rx entries
  input  logic            rd_strobe_i,    // Pop the tx head
  output jsp_pkg::byte_t  rd_head_o,
  output jsp_pkg::count_t bytes_avail_o,  // Bytes waiting for the host
  // Receive port, host to device
  output logic            rx_req_o,
  output jsp_pkg::byte_t  rx_data_o,
  input  logic            rx_ack_i,
  // Transmit port, device to host
  input  logic            tx_req_i,
  input  jsp_pkg::byte_t  tx_data_i,
  output logic            tx_ack_o
);

  jsp_pkg::count_t rx_count;
  logic            rx_pop;
  logic            rx_req_q;
  logic            tx_full;
  logic            tx_push;
  logic            tx_ack_q;

  ////////////////////
  // FIFOs
  ////////////////////

  jsp_fifo rx_fifo (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .push_i     (wr_strobe_i),
    .push_data_i(wr_data_i),
    .pop_i      (rx_pop),
    .head_o     (rx_data_o),   // Head goes straight to the port
    .count_o    (rx_count),
    .full_o     ()             // Host never sends past the captured space
  );

  jsp_fifo tx_fifo (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .push_i     (tx_push),
    .push_data_i(tx_data_i),
    .pop_i      (rd_strobe_i),
    .head_o     (rd_head_o),
    .count_o    (bytes_avail_o),
    .full_o     (tx_full)
  );

  assign space_avail_o = jsp_pkg::count_t'(`JSP_FIFO_DEPTH) - rx_count;

  ////////////////////
  // Four-phase ports
  ////////////////////

  assign rx_pop   = rx_req_q && rx_ack_i;               // Ack seen, byte taken
  assign tx_push  = tx_req_i && !tx_ack_q && !tx_full;  // New request with room
  assign rx_req_o = rx_req_q;
  assign tx_ack_o = tx_ack_q;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      rx_req_q <= 1'b0;
      tx_ack_q <= 1'b0;
    end else begin
      // Request only after the previous ack is gone
      if (rx_pop) begin
        rx_req_q <= 1'b0;
      end else if (!rx_req_q && !rx_ack_i && (rx_count != '0)) begin
        rx_req_q <= 1'b1;
      end
      // Ack held until the system drops its request
      if (tx_push) begin
        tx_ack_q <= 1'b1;
      end else if (tx_ack_q && !tx_req_i) begin
        tx_ack_q <= 1'b0;
      end
    end
  end

endmodule

// ==== logic/jsp_wr_ctrl.sv ====
////////////////////
// Host to device controller
// Waits for the start bit, takes the count byte, then
// assembles data bytes LSB first and strobes them out
////////////////////

`timescale 1ns/1ns

`include "jsp_cfg.svh"

module jsp_wr_ctrl (
  input  logic            tck_i,
  input  logic            rst_i,
  input  logic            tdi_i,
  input  logic            capture_dr_i,
  input  logic            shift_dr_i,
  input  logic            update_dr_i,
  input  logic            module_select_i,
  input  jsp_pkg::count_t space_avail_i,  // Snapshot taken at capture
  output logic            wr_strobe_o,    // One cycle per accepted byte
  output jsp_pkg::byte_t  wr_data_o
);

  jsp_pkg::wr_state_t state_q;
  jsp_pkg::wr_state_t state_d;
  jsp_pkg::bit_cnt_t  bit_cnt_q;
  jsp_pkg::byte_t     shift_q;      // Shift-in register
  jsp_pkg::byte_t     shift_d;
  jsp_pkg::count_t    space_cnt_q;  // Room left in rx FIFO
  jsp_pkg::count_t    user_cnt_q;   // Bytes the host still means to send
  logic               strobe_q;
  logic               bit_max;
  logic               accept;

  assign bit_max = (bit_cnt_q == jsp_pkg::bit_cnt_t'(`JSP_BIT_MAX));
  assign shift_d = {tdi_i, shift_q[`JSP_WORD_W-1:1]};  // LSB arrives first
  // Last bit of a data byte with both counters open
  assign accept  = (state_q == jsp_pkg::WR_XFER) && shift_dr_i && bit_max &&
                   (space_cnt_q != '0) && (user_cnt_q != '0);

  assign wr_strobe_o = strobe_q;
  assign wr_data_o   = shift_q;  // Complete byte during the strobe cycle

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      jsp_pkg::WR_IDLE: begin
        if (module_select_i && capture_dr_i) state_d = jsp_pkg::WR_WAIT;
      end
      jsp_pkg::WR_WAIT: begin
        if (update_dr_i) begin
          state_d = jsp_pkg::WR_IDLE;
        end else if (shift_dr_i && module_select_i && (tdi_i == `JSP_START_BIT)) begin
          state_d = jsp_pkg::WR_COUNTS;  // Start bit seen
        end
      end
      jsp_pkg::WR_COUNTS: begin
        if (update_dr_i)                 state_d = jsp_pkg::WR_IDLE;
        else if (shift_dr_i && bit_max)  state_d = jsp_pkg::WR_XFER;
      end
      default: begin  // WR_XFER runs until update
        if (update_dr_i) state_d = jsp_pkg::WR_IDLE;
      end
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge tck_i) begin
    if (shift_dr_i) shift_q <= shift_d;
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q     <= jsp_pkg::WR_IDLE;
      bit_cnt_q   <= '0;
      space_cnt_q <= '0;
      user_cnt_q  <= '0;
      strobe_q    <= 1'b0;
    end else begin
      state_q  <= state_d;
      strobe_q <= accept;
      if (state_q == jsp_pkg::WR_IDLE && state_d == jsp_pkg::WR_WAIT) begin
        space_cnt_q <= space_avail_i;
      end else if (accept) begin
        space_cnt_q <= space_cnt_q - jsp_pkg::count_t'(1);
      end
      // Upper nibble of the count byte
      if (state_q == jsp_pkg::WR_COUNTS && shift_dr_i && bit_max) begin
        user_cnt_q <= shift_d[`JSP_WORD_W-1 -: `JSP_COUNT_W];
      end else if (accept) begin
        user_cnt_q <= user_cnt_q - jsp_pkg::count_t'(1);
      end
      if (state_q == jsp_pkg::WR_WAIT) begin
        bit_cnt_q <= '0;
      end else if (shift_dr_i && state_q != jsp_pkg::WR_IDLE) begin
        bit_cnt_q <= bit_cnt_q + jsp_pkg::bit_cnt_t'(1);  // Wraps per byte
      end
    end
  end

endmodule

// ==== logic/jsp_rd_ctrl.sv ====
////////////////////
// Device to host controller
// Shifts out the status byte, then bytes popped from
// the tx FIFO, LSB first on tdo
////////////////////

`timescale 1ns/1ns

`include "jsp_cfg.svh"

module jsp_rd_ctrl (
  input  logic            tck_i,
  input  logic            rst_i,
  input  logic            capture_dr_i,
  input  logic            shift_dr_i,
  input  logic            update_dr_i,
  input  logic            module_select_i,
  input  jsp_pkg::count_t space_avail_i,  // Low status nibble
  input  jsp_pkg::count_t bytes_avail_i,  // High status nibble
  input  jsp_pkg::byte_t  rd_head_i,      // tx FIFO head
  output logic            rd_strobe_o,    // Pop the head
  output logic            tdo_o
);

  jsp_pkg::rd_state_t state_q;
  jsp_pkg::rd_state_t state_d;
  jsp_pkg::bit_cnt_t  bit_cnt_q;
  jsp_pkg::count_t    out_cnt_q;  // Bytes still owed to the host
  jsp_pkg::byte_t     shift_q;    // Parallel-load output register
  logic               bit_max;
  logic               out_cnt_zero;
  logic               start;      // Capture while selected
  logic               load_head;  // End of a byte with data to follow

  assign bit_max      = (bit_cnt_q == jsp_pkg::bit_cnt_t'(`JSP_BIT_MAX));
  assign out_cnt_zero = (out_cnt_q == '0);
  assign start        = (state_q == jsp_pkg::RD_IDLE) && module_select_i && capture_dr_i;
  assign load_head    = shift_dr_i && bit_max && !out_cnt_zero &&
                        (state_q == jsp_pkg::RD_COUNTS || state_q == jsp_pkg::RD_XFER);

  // Pop on the first bit of each data byte while count allows
  assign rd_strobe_o = (state_q == jsp_pkg::RD_RDACK) && shift_dr_i && !out_cnt_zero;
  assign tdo_o       = shift_q[0];

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      jsp_pkg::RD_IDLE: begin
        if (start) state_d = jsp_pkg::RD_COUNTS;
      end
      jsp_pkg::RD_COUNTS: begin
        if (update_dr_i)                 state_d = jsp_pkg::RD_IDLE;
        else if (shift_dr_i && bit_max)  state_d = jsp_pkg::RD_RDACK;
      end
      jsp_pkg::RD_RDACK: begin
        if (update_dr_i)      state_d = jsp_pkg::RD_IDLE;
        else if (shift_dr_i)  state_d = jsp_pkg::RD_XFER;  // Never the last bit
      end
      default: begin  // RD_XFER
        if (update_dr_i)                 state_d = jsp_pkg::RD_IDLE;
        else if (shift_dr_i && bit_max)  state_d = jsp_pkg::RD_RDACK;
      end
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= jsp_pkg::RD_IDLE;
      bit_cnt_q <= '0;
      out_cnt_q <= '0;
      shift_q   <= '0;  // tdo low out of reset
    end else begin
      state_q <= state_d;
      if (start) begin
        shift_q   <= {bytes_avail_i, space_avail_i};  // Status byte
        out_cnt_q <= bytes_avail_i;
        bit_cnt_q <= '0;
      end else if (shift_dr_i && state_q != jsp_pkg::RD_IDLE) begin
        bit_cnt_q <= bit_cnt_q + jsp_pkg::bit_cnt_t'(1);
        if (load_head) begin
          shift_q <= rd_head_i;  // Next byte, popped later in RD_RDACK
        end else begin
          shift_q <= {1'b0, shift_q[`JSP_WORD_W-1:1]};
        end
        // One byte sent
        if (state_q == jsp_pkg::RD_XFER && bit_max && !out_cnt_zero) begin
          out_cnt_q <= out_cnt_q - jsp_pkg::count_t'(1);
        end
      end
    end
  end

endmodule

// ==== logic/jsp_top.sv ====
////////////////////
// Top of the JTAG serial port
// TAP controls in, tdo out, two four-phase byte ports
////////////////////

`timescale 1ns/1ns

module jsp_top (
  input  logic           tck_i,
  input  logic           rst_i,
  // TAP side
  input  logic           tdi_i,
  input  logic           capture_dr_i,
  input  logic           shift_dr_i,
  input  logic           update_dr_i,
  input  logic           module_select_i,
  output logic           tdo_o,
  // System side
  output logic           rx_req_o,
  output jsp_pkg::byte_t rx_data_o,
  input  logic           rx_ack_i,
  input  logic           tx_req_i,
  input  jsp_pkg::byte_t tx_data_i,
  output logic           tx_ack_o
);

  logic            wr_strobe;
  jsp_pkg::byte_t  wr_data;
  jsp_pkg::count_t space_avail;  // Free rx entries
  logic            rd_strobe;
  jsp_pkg::byte_t  rd_head;
  jsp_pkg::count_t bytes_avail;  // Queued tx bytes

  // Host to device
  jsp_wr_ctrl u_wr_ctrl (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .tdi_i          (tdi_i),
    .capture_dr_i   (capture_dr_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .module_select_i(module_select_i),
    .space_avail_i  (space_avail),
    .wr_strobe_o    (wr_strobe),
    .wr_data_o      (wr_data)
  );

  // Device to host
  jsp_rd_ctrl u_rd_ctrl (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .capture_dr_i   (capture_dr_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .module_select_i(module_select_i),
    .space_avail_i  (space_avail),
    .bytes_avail_i  (bytes_avail),
    .rd_head_i      (rd_head),
    .rd_strobe_o    (rd_strobe),
    .tdo_o          (tdo_o)
  );

  jsp_bus_unit u_bus_unit (
    .tck_i        (tck_i),
    .rst_i        (rst_i),
    .wr_strobe_i  (wr_strobe),
    .wr_data_i    (wr_data),
    .space_avail_o(space_avail),
    .rd_strobe_i  (rd_strobe),
    .rd_head_o    (rd_head),
    .bytes_avail_o(bytes_avail),
    .rx_req_o     (rx_req_o),
    .rx_data_o    (rx_data_o),
    .rx_ack_i     (rx_ack_i),
    .tx_req_i     (tx_req_i),
    .tx_data_i    (tx_data_i),
    .tx_ack_o     (tx_ack_o)
  );

endmodule

// ==== sim/jsp_tb.sv ====
////////////////////
// Testbench for the JTAG serial port
// Random JTAG scans and four-phase agents on both byte ports,
// checked against queue models of the two FIFOs
////////////////////

`timescale 1ns/1ns

`include "jsp_cfg.svh"

module jsp_tb;

  localparam int TIMEOUT = 200;  // Cycles allowed per wait

  logic           tck;
  logic           rst;
  logic           tdi;
  logic           capture_dr;
  logic           shift_dr;
  logic           update_dr;
  logic           module_select;
  logic           tdo;
  logic           rx_req;
  jsp_pkg::byte_t rx_data;
  logic           rx_ack;
  logic           tx_req;
  jsp_pkg::byte_t tx_data;
  logic           tx_ack;

  jsp_pkg::byte_t model_rx[$];  // Bytes expected in the rx FIFO
  jsp_pkg::byte_t model_tx[$];  // Bytes expected in the tx FIFO
  logic [15:0]    lfsr_state;   // Random source

  jsp_top dut (
    .tck_i          (tck),
    .rst_i          (rst),
    .tdi_i          (tdi),
    .capture_dr_i   (capture_dr),
    .shift_dr_i     (shift_dr),
    .update_dr_i    (update_dr),
    .module_select_i(module_select),
    .tdo_o          (tdo),
    .rx_req_o       (rx_req),
    .rx_data_o      (rx_data),
    .rx_ack_i       (rx_ack),
    .tx_req_i       (tx_req),
    .tx_data_i      (tx_data),
    .tx_ack_o       (tx_ack)
  );

  initial begin
    tck = 1'b0;
    forever #4 tck = ~tck;  // 8 ns period
  end

  ////////////////////
  // Random numbers
  ////////////////////

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic next_bit();
    logic out;
    out        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ 16'hB400;
    return out;
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++)
      r = {r[14:0], next_bit()};  // One step per bit
    return r;
  endfunction

  ////////////////////
  // Checks and waits
  ////////////////////

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "Simulation stopped on first failure");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic wait_rx_req(input logic level);
    int cycles;
    cycles = 0;
    while (rx_req !== level) begin
      @(negedge tck);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("Timeout: rx_req_o stuck, never went to %0b", level);
        abort_run();
      end
    end
  endtask

  task automatic wait_tx_ack(input logic level);
    int cycles;
    cycles = 0;
    while (tx_ack !== level) begin
      @(negedge tck);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("Timeout: tx_ack_o stuck, never went to %0b", level);
        abort_run();
      end
    end
  endtask

  ////////////////////
  // System side agents
  ////////////////////

  // Take every expected byte off the rx port, four-phase
  task automatic drain_rx();
    jsp_pkg::byte_t exp;
    int             delay;
    while (model_rx.size() > 0) begin
      exp = model_rx.pop_front();
      wait_rx_req(1'b1);
      check_eq(rx_data, exp, "rx_data_o");
      delay = rand_bits(3);       // Random ack latency
      repeat (delay) @(negedge tck);
      check_eq(rx_data, exp, "rx_data_o held during request");
      rx_ack = 1'b1;
      wait_rx_req(1'b0);
      rx_ack = 1'b0;
    end
    repeat (3) @(negedge tck);
    check_eq(rx_req, 1'b0, "rx_req_o after last byte");  // No extra bytes
  endtask

  task automatic push_tx(input jsp_pkg::byte_t data);
    @(negedge tck);
    tx_data = data;
    tx_req  = 1'b1;
    wait_tx_ack(1'b1);
    tx_req  = 1'b0;
    wait_tx_ack(1'b0);
    model_tx.push_back(data);
  endtask

  ////////////////////
  // JTAG scan and model
  ////////////////////

  // Capture, leading zeros, start bit, count byte, data, update
  task automatic run_scan(input int n_read, input int n_data, input logic [3:0] user,
                          input int part_bits);
    logic           tdi_bits[$];
    logic           tdo_bits[$];
    jsp_pkg::byte_t data;
    int             lead;
    int             total;
    int             space0;
    int             avail0;
    int             n_acc;
    int             n_check;
    int             i;
    int             k;
    space0 = `JSP_FIFO_DEPTH - model_rx.size();  // Snapshot at capture
    avail0 = model_tx.size();
    lead   = rand_bits(3);
    repeat (lead) tdi_bits.push_back(1'b0);
    tdi_bits.push_back(`JSP_START_BIT);
    data = rand_bits(8);
    data = {user, data[3:0]};                     // Count byte, low nibble ignored
    for (i = 0; i < `JSP_WORD_W; i++)
      tdi_bits.push_back(data[i]);
    for (k = 0; k < n_data; k++) begin
      data = rand_bits(8);
      for (i = 0; i < `JSP_WORD_W; i++)
        tdi_bits.push_back(data[i]);                // LSB first
    end
    repeat (part_bits) tdi_bits.push_back(next_bit());  // Partial byte, dropped
    total = tdi_bits.size();
    if (total < 8 + 8 * n_read) total = 8 + 8 * n_read;
    while (tdi_bits.size() < total) tdi_bits.push_back(1'b0);

    @(negedge tck);
    capture_dr = 1'b1;
    for (i = 0; i < total; i++) begin
      @(negedge tck);
      capture_dr = 1'b0;
      shift_dr   = 1'b1;
      tdi        = tdi_bits[i];
      tdo_bits.push_back(tdo);                    // Bit before its shift edge
    end
    @(negedge tck);
    shift_dr  = 1'b0;
    tdi       = 1'b0;
    update_dr = 1'b1;
    @(negedge tck);
    update_dr = 1'b0;
    @(negedge tck);                               // Last strobe lands here

    for (i = 0; i < `JSP_WORD_W; i++)
      data[i] = tdo_bits[i];
    check_eq(data[3:0], space0, "status free space");
    check_eq(data[7:4], avail0, "status tx bytes");
    // Only bytes owed at capture and fully shifted
    n_check = total / 8 - 1;
    if (n_check > avail0) n_check = avail0;
    for (k = 0; k < n_check; k++) begin
      for (i = 0; i < `JSP_WORD_W; i++)
        data[i] = tdo_bits[8 + 8 * k + i];
      check_eq(data, model_tx[k], "host read byte");
    end
    k = (total - 1) / 8;                          // Pop on first bit of each byte
    if (k > avail0) k = avail0;
    repeat (k) data = model_tx.pop_front();
    // Write side keeps whole bytes within user count and space
    n_acc = (total - lead - 9) / 8;
    if (n_acc > user) n_acc = user;
    if (n_acc > space0) n_acc = space0;
    for (k = 0; k < n_acc; k++) begin
      for (i = 0; i < `JSP_WORD_W; i++)
        data[i] = tdi_bits[lead + 9 + 8 * k + i];
      model_rx.push_back(data);
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    jsp_pkg::byte_t data;
    int             round;
    int             k;
    int             n_read;
    int             hold;
    logic [3:0]     user;
    lfsr_state    = 16'd5414;
    rst           = 1'b1;
    tdi           = 1'b0;
    capture_dr    = 1'b0;
    shift_dr      = 1'b0;
    update_dr     = 1'b0;
    module_select = 1'b0;
    rx_ack        = 1'b0;
    tx_req        = 1'b0;
    tx_data       = '0;
    repeat (10) @(negedge tck);
    rst           = 1'b0;
    module_select = 1'b1;
    check_eq(tdo, 1'b0, "tdo_o after reset");
    check_eq(rx_req, 1'b0, "rx_req_o after reset");
    check_eq(tx_ack, 1'b0, "tx_ack_o after reset");
    run_scan(0, 0, 4'd0, 0);                      // Status 8 free, 0 queued

    // Random reads, writes and overruns
    for (round = 0; round < 12; round++) begin
      k = rand_bits(4) % (`JSP_FIFO_DEPTH + 1 - model_tx.size());
      repeat (k) begin
        data = rand_bits(8);
        push_tx(data);
      end
      n_read = rand_bits(1) ? model_tx.size() : rand_bits(4) % (model_tx.size() + 1);
      user   = rand_bits(4);
      run_scan(n_read, rand_bits(4) % 11, user, 0);
      if (rand_bits(1)) drain_rx();               // Else next scan sees less space
    end
    drain_rx();

    // Back-pressure with the tx FIFO full
    while (model_tx.size() < `JSP_FIFO_DEPTH) begin
      data = rand_bits(8);
      push_tx(data);
    end
    @(negedge tck);
    data    = rand_bits(8);
    tx_data = data;
    tx_req  = 1'b1;
    hold    = 8 + rand_bits(4);
    repeat (hold) begin
      @(negedge tck);
      check_eq(tx_ack, 1'b0, "tx_ack_o with tx FIFO full");
    end
    run_scan(1, 0, 4'd0, 0);                      // Frees one entry
    wait_tx_ack(1'b1);
    tx_req = 1'b0;
    wait_tx_ack(1'b0);
    model_tx.push_back(data);
    run_scan(model_tx.size(), 0, 4'd0, 0);

    // Update in the middle of a data byte
    k = 1 + rand_bits(2);
    run_scan(0, k, 4'hF, 1 + rand_bits(3) % 7);
    drain_rx();
    run_scan(0, 0, 4'd0, 0);

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+include
logic/jsp_pkg.sv
logic/jsp_fifo.sv
logic/jsp_bus_unit.sv
logic/jsp_wr_ctrl.sv
logic/jsp_rd_ctrl.sv
logic/jsp_top.sv
sim/jsp_tb.sv

// ==== Bender.yml ====
package:
  name: jsp

sources:
  - include_dirs:
      - include
    files:
      - logic/jsp_pkg.sv
      - logic/jsp_fifo.sv
      - logic/jsp_bus_unit.sv
      - logic/jsp_wr_ctrl.sv
      - logic/jsp_rd_ctrl.sv
      - logic/jsp_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/jsp_tb.sv
